//--- logic/fwd_params.svh
`ifndef FWD_PARAMS_SVH
`define FWD_PARAMS_SVH

// Width of an integer operand or result
`define FWD_XLEN 32

// Architectural register number width, 32 registers
`define FWD_REG_ADDR_W 5

`endif

//--- logic/fwd_types_pkg.sv
`include "fwd_params.svh"

package fwd_types_pkg;

    // Operand or result value as it travels down the pipeline
    typedef logic [`FWD_XLEN-1:0] data_t;

    // Architectural register number
    // Register 0 reads as zero and never creates a dependency
    typedef logic [`FWD_REG_ADDR_W-1:0] reg_addr_t;

endpackage : fwd_types_pkg

//--- logic/bypass_sel_pkg.sv
`include "fwd_params.svh"

package bypass_sel_pkg;

    // Operand source chosen in decode
    typedef enum logic [1:0] {
        ID_RF            = 2'd0,
        EXECUTE_BYPASS   = 2'd1,
        MEMORY_BYPASS    = 2'd2,
        WRITEBACK_BYPASS = 2'd3
    } bypass_id_sel_e;

    // Late correction applied in execute, one stage older than in decode
    typedef enum logic [1:0] {
        NO_BYPASS  = 2'd0,
        MEM_BYPASS = 2'd1,
        WB_BYPASS  = 2'd2
    } bypass_ex_sel_e;

endpackage : bypass_sel_pkg

//--- logic/dependency_check.sv
`timescale 1ns/1ps

`include "fwd_params.svh"

module dependency_check (
    input  fwd_types_pkg::reg_addr_t rs_a_id_i,
    input  fwd_types_pkg::reg_addr_t rs_b_id_i,
    input  fwd_types_pkg::reg_addr_t rd_ex_i,
    input  fwd_types_pkg::reg_addr_t rd_mem_i,
    input  fwd_types_pkg::reg_addr_t rd_wb_i,

    output logic                     dep_ex_a_o,
    output logic                     dep_ex_b_o,
    output logic                     dep_mem_a_o,
    output logic                     dep_mem_b_o,
    output logic                     dep_wb_a_o,
    output logic                     dep_wb_b_o
);

    // Address match, x0 is excluded since it is never written
    function automatic logic reg_match(
        input fwd_types_pkg::reg_addr_t src,
        input fwd_types_pkg::reg_addr_t dst
    );
        return (src == dst) && (src != '0);
    endfunction

    // Stage valid bits are left to the controller
    assign dep_ex_a_o  = reg_match(rs_a_id_i, rd_ex_i);
    assign dep_ex_b_o  = reg_match(rs_b_id_i, rd_ex_i);

    assign dep_mem_a_o = reg_match(rs_a_id_i, rd_mem_i);
    assign dep_mem_b_o = reg_match(rs_b_id_i, rd_mem_i);

    assign dep_wb_a_o  = reg_match(rs_a_id_i, rd_wb_i);
    assign dep_wb_b_o  = reg_match(rs_b_id_i, rd_wb_i);

endmodule : dependency_check

//--- logic/bypass_controller.sv
`timescale 1ns/1ps

`include "fwd_params.svh"

module bypass_controller (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Decode stage
    input  logic                           valid_id_i,
    output bypass_sel_pkg::bypass_id_sel_e mux_sel_a_id_o,
    output bypass_sel_pkg::bypass_id_sel_e mux_sel_b_id_o,

    // Execute stage
    input  logic                           valid_ex_i,
    input  logic                           data_produced_ex_i,
    input  logic                           is_load_ex_i,
    input  logic                           dep_ex_a_i,
    input  logic                           dep_ex_b_i,
    output bypass_sel_pkg::bypass_ex_sel_e mux_sel_a_ex_o,
    output bypass_sel_pkg::bypass_ex_sel_e mux_sel_b_ex_o,
    output bypass_sel_pkg::bypass_ex_sel_e mux_sel_load_ex_o,

    // Memory stage
    input  logic                           valid_mem_i,
    input  logic                           data_produced_mem_i,
    input  logic                           is_load_mem_i,
    input  logic                           dep_mem_a_i,
    input  logic                           dep_mem_b_i,

    // Writeback stage, its result is always ready
    input  logic                           valid_wb_i,
    input  logic                           dep_wb_a_i,
    input  logic                           dep_wb_b_i
);

    logic                           fwd_en_q;
    logic                           ex_ready;
    logic                           mem_ready;
    logic                           use_ex_a;
    logic                           use_ex_b;
    logic                           use_mem_a;
    logic                           use_mem_b;
    bypass_sel_pkg::bypass_id_sel_e sel_a_id;
    bypass_sel_pkg::bypass_id_sel_e sel_b_id;

    // Youngest producer with its result in hand wins
    function automatic bypass_sel_pkg::bypass_id_sel_e id_select(
        input logic from_ex,
        input logic from_mem,
        input logic from_wb
    );
        if (from_ex) begin
            return bypass_sel_pkg::EXECUTE_BYPASS;
        end else if (from_mem) begin
            return bypass_sel_pkg::MEMORY_BYPASS;
        end else if (from_wb) begin
            return bypass_sel_pkg::WRITEBACK_BYPASS;
        end
        return bypass_sel_pkg::ID_RF;
    endfunction

    // Producer in EX lands in MEM next cycle, producer in MEM lands in WB
    function automatic bypass_sel_pkg::bypass_ex_sel_e ex_select(
        input logic late_ex,
        input logic late_mem
    );
        if (late_ex) begin
            return bypass_sel_pkg::MEM_BYPASS;
        end else if (late_mem) begin
            return bypass_sel_pkg::WB_BYPASS;
        end
        return bypass_sel_pkg::NO_BYPASS;
    endfunction

    // Forwarding stays off until the first clock edge out of reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fwd_en_q <= 1'b0;
        end else begin
            fwd_en_q <= 1'b1;
        end
    end

    assign ex_ready  = valid_ex_i && data_produced_ex_i;
    assign mem_ready = valid_mem_i && data_produced_mem_i;

    assign sel_a_id = fwd_en_q ?
        id_select(ex_ready && dep_ex_a_i, mem_ready && dep_mem_a_i, valid_wb_i && dep_wb_a_i) :
        bypass_sel_pkg::ID_RF;
    assign sel_b_id = fwd_en_q ?
        id_select(ex_ready && dep_ex_b_i, mem_ready && dep_mem_b_i, valid_wb_i && dep_wb_b_i) :
        bypass_sel_pkg::ID_RF;

    assign mux_sel_a_id_o = sel_a_id;
    assign mux_sel_b_id_o = sel_b_id;

    // One-hot record of which decode bypass was taken
    assign use_ex_a  = (sel_a_id == bypass_sel_pkg::EXECUTE_BYPASS);
    assign use_ex_b  = (sel_b_id == bypass_sel_pkg::EXECUTE_BYPASS);
    assign use_mem_a = (sel_a_id == bypass_sel_pkg::MEMORY_BYPASS);
    assign use_mem_b = (sel_b_id == bypass_sel_pkg::MEMORY_BYPASS);

    // No data_produced test here, the result exists one cycle later anyway
    always_comb begin
        mux_sel_a_ex_o    = bypass_sel_pkg::NO_BYPASS;
        mux_sel_b_ex_o    = bypass_sel_pkg::NO_BYPASS;
        mux_sel_load_ex_o = bypass_sel_pkg::NO_BYPASS;
        if (fwd_en_q && valid_id_i) begin
            mux_sel_a_ex_o = ex_select(
                valid_ex_i && dep_ex_a_i && !use_ex_a,
                valid_mem_i && dep_mem_a_i && !use_mem_a && !use_ex_a);
            mux_sel_b_ex_o = ex_select(
                valid_ex_i && dep_ex_b_i && !use_ex_b,
                valid_mem_i && dep_mem_b_i && !use_mem_b && !use_ex_b);
            // Store data from a load still in flight
            mux_sel_load_ex_o = ex_select(
                valid_ex_i && is_load_ex_i && dep_ex_b_i,
                valid_mem_i && is_load_mem_i && dep_mem_b_i);
        end
    end

endmodule : bypass_controller

//--- logic/id_operand_mux.sv
`timescale 1ns/1ps

`include "fwd_params.svh"

module id_operand_mux (
    input  bypass_sel_pkg::bypass_id_sel_e mux_sel_a_i,
    input  bypass_sel_pkg::bypass_id_sel_e mux_sel_b_i,

    input  fwd_types_pkg::data_t           rf_rdata_a_i,
    input  fwd_types_pkg::data_t           rf_rdata_b_i,
    input  fwd_types_pkg::data_t           ex_result_i,
    input  fwd_types_pkg::data_t           mem_result_i,
    input  fwd_types_pkg::data_t           wb_result_i,

    output fwd_types_pkg::data_t           id_op_a_o,
    output fwd_types_pkg::data_t           id_op_b_o
);

    // Four-way operand select shared by both sources
    function automatic fwd_types_pkg::data_t pick(
        input bypass_sel_pkg::bypass_id_sel_e sel,
        input fwd_types_pkg::data_t           rf_data,
        input fwd_types_pkg::data_t           ex_data,
        input fwd_types_pkg::data_t           mem_data,
        input fwd_types_pkg::data_t           wb_data
    );
        case (sel)
            bypass_sel_pkg::EXECUTE_BYPASS:   return ex_data;
            bypass_sel_pkg::MEMORY_BYPASS:    return mem_data;
            bypass_sel_pkg::WRITEBACK_BYPASS: return wb_data;
            default:                          return rf_data;
        endcase
    endfunction

    assign id_op_a_o = pick(mux_sel_a_i, rf_rdata_a_i, ex_result_i, mem_result_i, wb_result_i);
    assign id_op_b_o = pick(mux_sel_b_i, rf_rdata_b_i, ex_result_i, mem_result_i, wb_result_i);

endmodule : id_operand_mux

//--- logic/ex_operand_stage.sv
`timescale 1ns/1ps

`include "fwd_params.svh"

module ex_operand_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // From decode
    input  logic                           valid_id_i,
    input  fwd_types_pkg::data_t           id_op_a_i,
    input  fwd_types_pkg::data_t           id_op_b_i,
    input  bypass_sel_pkg::bypass_ex_sel_e sel_a_i,
    input  bypass_sel_pkg::bypass_ex_sel_e sel_b_i,
    input  bypass_sel_pkg::bypass_ex_sel_e sel_load_i,

    // Results of the older instructions, one cycle on
    input  fwd_types_pkg::data_t           mem_result_i,
    input  fwd_types_pkg::data_t           wb_result_i,

    output logic                           ex_valid_o,
    output fwd_types_pkg::data_t           ex_op_a_o,
    output fwd_types_pkg::data_t           ex_op_b_o,
    output fwd_types_pkg::data_t           ex_store_data_o
);

    fwd_types_pkg::data_t           op_a_q;
    fwd_types_pkg::data_t           op_b_q;
    bypass_sel_pkg::bypass_ex_sel_e sel_a_q;
    bypass_sel_pkg::bypass_ex_sel_e sel_b_q;
    bypass_sel_pkg::bypass_ex_sel_e sel_load_q;

    function automatic fwd_types_pkg::data_t correct(
        input bypass_sel_pkg::bypass_ex_sel_e sel,
        input fwd_types_pkg::data_t           held,
        input fwd_types_pkg::data_t           mem_data,
        input fwd_types_pkg::data_t           wb_data
    );
        case (sel)
            bypass_sel_pkg::MEM_BYPASS: return mem_data;
            bypass_sel_pkg::WB_BYPASS:  return wb_data;
            default:                    return held;
        endcase
    endfunction

    // ID/EX register, the pipeline never stalls
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            op_a_q     <= '0;
            op_b_q     <= '0;
            sel_a_q    <= bypass_sel_pkg::NO_BYPASS;
            sel_b_q    <= bypass_sel_pkg::NO_BYPASS;
            sel_load_q <= bypass_sel_pkg::NO_BYPASS;
        end else begin
            ex_valid_o <= valid_id_i;
            op_a_q     <= id_op_a_i;
            op_b_q     <= id_op_b_i;
            sel_a_q    <= sel_a_i;
            sel_b_q    <= sel_b_i;
            sel_load_q <= sel_load_i;
        end
    end

    assign ex_op_a_o = correct(sel_a_q, op_a_q, mem_result_i, wb_result_i);
    assign ex_op_b_o = correct(sel_b_q, op_b_q, mem_result_i, wb_result_i);

    // Store data follows operand B, loaded value takes over when still in flight
    assign ex_store_data_o = correct(sel_load_q, ex_op_b_o, mem_result_i, wb_result_i);

endmodule : ex_operand_stage

//--- logic/forwarding_unit.sv
`timescale 1ns/1ps

`include "fwd_params.svh"

module forwarding_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Instruction in decode
    input  logic                      valid_id_i,
    input  fwd_types_pkg::reg_addr_t  rs_a_id_i,
    input  fwd_types_pkg::reg_addr_t  rs_b_id_i,
    input  fwd_types_pkg::data_t      rf_rdata_a_i,
    input  fwd_types_pkg::data_t      rf_rdata_b_i,

    // Execute stage
    input  logic                      valid_ex_i,
    input  fwd_types_pkg::reg_addr_t  rd_ex_i,
    input  logic                      data_produced_ex_i,
    input  logic                      is_load_ex_i,
    input  fwd_types_pkg::data_t      ex_result_i,

    // Memory stage
    input  logic                      valid_mem_i,
    input  fwd_types_pkg::reg_addr_t  rd_mem_i,
    input  logic                      data_produced_mem_i,
    input  logic                      is_load_mem_i,
    input  fwd_types_pkg::data_t      mem_result_i,

    // Writeback stage
    input  logic                      valid_wb_i,
    input  fwd_types_pkg::reg_addr_t  rd_wb_i,
    input  fwd_types_pkg::data_t      wb_result_i,

    output fwd_types_pkg::data_t      id_op_a_o,
    output fwd_types_pkg::data_t      id_op_b_o,
    output logic                      ex_valid_o,
    output fwd_types_pkg::data_t      ex_op_a_o,
    output fwd_types_pkg::data_t      ex_op_b_o,
    output fwd_types_pkg::data_t      ex_store_data_o
);

    logic                           depEX_src_a;
    logic                           depEX_src_b;
    logic                           depMEM_src_a;
    logic                           depMEM_src_b;
    logic                           depWB_src_a;
    logic                           depWB_src_b;
    bypass_sel_pkg::bypass_id_sel_e mux_sel_a_id;
    bypass_sel_pkg::bypass_id_sel_e mux_sel_b_id;
    bypass_sel_pkg::bypass_ex_sel_e mux_sel_a_ex;
    bypass_sel_pkg::bypass_ex_sel_e mux_sel_b_ex;
    bypass_sel_pkg::bypass_ex_sel_e mux_sel_load_ex;
    fwd_types_pkg::data_t           id_op_a;
    fwd_types_pkg::data_t           id_op_b;

    dependency_check dependency_check_inst (
        .rs_a_id_i   (rs_a_id_i),
        .rs_b_id_i   (rs_b_id_i),
        .rd_ex_i     (rd_ex_i),
        .rd_mem_i    (rd_mem_i),
        .rd_wb_i     (rd_wb_i),
        .dep_ex_a_o  (depEX_src_a),
        .dep_ex_b_o  (depEX_src_b),
        .dep_mem_a_o (depMEM_src_a),
        .dep_mem_b_o (depMEM_src_b),
        .dep_wb_a_o  (depWB_src_a),
        .dep_wb_b_o  (depWB_src_b)
    );

    bypass_controller bypass_controller_inst (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .valid_id_i          (valid_id_i),
        .mux_sel_a_id_o      (mux_sel_a_id),
        .mux_sel_b_id_o      (mux_sel_b_id),
        .valid_ex_i          (valid_ex_i),
        .data_produced_ex_i  (data_produced_ex_i),
        .is_load_ex_i        (is_load_ex_i),
        .dep_ex_a_i          (depEX_src_a),
        .dep_ex_b_i          (depEX_src_b),
        .mux_sel_a_ex_o      (mux_sel_a_ex),
        .mux_sel_b_ex_o      (mux_sel_b_ex),
        .mux_sel_load_ex_o   (mux_sel_load_ex),
        .valid_mem_i         (valid_mem_i),
        .data_produced_mem_i (data_produced_mem_i),
        .is_load_mem_i       (is_load_mem_i),
        .dep_mem_a_i         (depMEM_src_a),
        .dep_mem_b_i         (depMEM_src_b),
        .valid_wb_i          (valid_wb_i),
        .dep_wb_a_i          (depWB_src_a),
        .dep_wb_b_i          (depWB_src_b)
    );

    id_operand_mux id_operand_mux_inst (
        .mux_sel_a_i  (mux_sel_a_id),
        .mux_sel_b_i  (mux_sel_b_id),
        .rf_rdata_a_i (rf_rdata_a_i),
        .rf_rdata_b_i (rf_rdata_b_i),
        .ex_result_i  (ex_result_i),
        .mem_result_i (mem_result_i),
        .wb_result_i  (wb_result_i),
        .id_op_a_o    (id_op_a),
        .id_op_b_o    (id_op_b)
    );

    ex_operand_stage ex_operand_stage_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .valid_id_i      (valid_id_i),
        .id_op_a_i       (id_op_a),
        .id_op_b_i       (id_op_b),
        .sel_a_i         (mux_sel_a_ex),
        .sel_b_i         (mux_sel_b_ex),
        .sel_load_i      (mux_sel_load_ex),
        .mem_result_i    (mem_result_i),
        .wb_result_i     (wb_result_i),
        .ex_valid_o      (ex_valid_o),
        .ex_op_a_o       (ex_op_a_o),
        .ex_op_b_o       (ex_op_b_o),
        .ex_store_data_o (ex_store_data_o)
    );

    assign id_op_a_o = id_op_a;
    assign id_op_b_o = id_op_b;

endmodule : forwarding_unit

//--- test/forwarding_properties.sv
`timescale 1ns/1ps

module forwarding_properties (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           ex_valid_i,
    input bypass_sel_pkg::bypass_id_sel_e sel_a_id_i,
    input bypass_sel_pkg::bypass_id_sel_e sel_b_id_i,
    input logic                           dep_a_i,
    input logic                           dep_b_i,
    input fwd_types_pkg::data_t           rf_rdata_a_i,
    input fwd_types_pkg::data_t           rf_rdata_b_i,
    input fwd_types_pkg::data_t           id_op_a_i,
    input fwd_types_pkg::data_t           id_op_b_i
);

    // ID/EX register stays empty through reset
    assert property (@(posedge clk_i) !rst_n_i |-> !ex_valid_i)
        else $error("ex_valid_o is high while reset is asserted");

    assert property (@(posedge clk_i) !$isunknown(sel_a_id_i))
        else $error("decode select of operand A is undefined");
    assert property (@(posedge clk_i) !$isunknown(sel_b_id_i))
        else $error("decode select of operand B is undefined");

    // No older stage writes the source, so the register file value goes through
    assert property (@(posedge clk_i) !dep_a_i |-> id_op_a_i == rf_rdata_a_i)
        else $error("operand A left the register file without a dependency");
    assert property (@(posedge clk_i) !dep_b_i |-> id_op_b_i == rf_rdata_b_i)
        else $error("operand B left the register file without a dependency");

endmodule : forwarding_properties

//--- test/forwarding_tb.sv
`timescale 1ns/1ps

module forwarding_tb;

    localparam int NUM_ROWS = 19;
    localparam int DATA_W   = $bits(fwd_types_pkg::data_t);

    localparam bypass_sel_pkg::bypass_id_sel_e SEL_RF  = bypass_sel_pkg::ID_RF;
    localparam bypass_sel_pkg::bypass_id_sel_e SEL_EX  = bypass_sel_pkg::EXECUTE_BYPASS;
    localparam bypass_sel_pkg::bypass_id_sel_e SEL_MEM = bypass_sel_pkg::MEMORY_BYPASS;
    localparam bypass_sel_pkg::bypass_id_sel_e SEL_WB  = bypass_sel_pkg::WRITEBACK_BYPASS;

    // One decode cycle with the decode select of each operand written by hand
    typedef struct packed {
        logic                           rst;
        logic                           vid;
        logic                           vex;
        fwd_types_pkg::reg_addr_t       rd_ex;
        logic                           dp_ex;
        logic                           ld_ex;
        logic                           vmem;
        fwd_types_pkg::reg_addr_t       rd_mem;
        logic                           dp_mem;
        logic                           ld_mem;
        logic                           vwb;
        fwd_types_pkg::reg_addr_t       rd_wb;
        fwd_types_pkg::reg_addr_t       rs_a;
        fwd_types_pkg::reg_addr_t       rs_b;
        bypass_sel_pkg::bypass_id_sel_e sel_a;
        bypass_sel_pkg::bypass_id_sel_e sel_b;
    } row_t;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     valid_id_i;
    fwd_types_pkg::reg_addr_t rs_a_id_i;
    fwd_types_pkg::reg_addr_t rs_b_id_i;
    fwd_types_pkg::data_t     rf_rdata_a_i;
    fwd_types_pkg::data_t     rf_rdata_b_i;
    logic                     valid_ex_i;
    fwd_types_pkg::reg_addr_t rd_ex_i;
    logic                     data_produced_ex_i;
    logic                     is_load_ex_i;
    fwd_types_pkg::data_t     ex_result_i;
    logic                     valid_mem_i;
    fwd_types_pkg::reg_addr_t rd_mem_i;
    logic                     data_produced_mem_i;
    logic                     is_load_mem_i;
    fwd_types_pkg::data_t     mem_result_i;
    logic                     valid_wb_i;
    fwd_types_pkg::reg_addr_t rd_wb_i;
    fwd_types_pkg::data_t     wb_result_i;
    fwd_types_pkg::data_t     id_op_a_o;
    fwd_types_pkg::data_t     id_op_b_o;
    logic                     ex_valid_o;
    fwd_types_pkg::data_t     ex_op_a_o;
    fwd_types_pkg::data_t     ex_op_b_o;
    fwd_types_pkg::data_t     ex_store_data_o;

    row_t                     rows [NUM_ROWS];
    string                    names [NUM_ROWS];
    logic [31:0]              lfsr_state = 32'd8;

    forwarding_unit forwarding_unit_inst (.*);

    bind forwarding_unit forwarding_properties forwarding_properties_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ex_valid_i   (ex_valid_o),
        .sel_a_id_i   (mux_sel_a_id),
        .sel_b_id_i   (mux_sel_b_id),
        .dep_a_i      (depEX_src_a || depMEM_src_a || depWB_src_a),
        .dep_b_i      (depEX_src_b || depMEM_src_b || depWB_src_b),
        .rf_rdata_a_i (rf_rdata_a_i),
        .rf_rdata_b_i (rf_rdata_b_i),
        .id_op_a_i    (id_op_a),
        .id_op_b_i    (id_op_b)
    );

    always #2 clk_i = ~clk_i;

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic fwd_types_pkg::data_t lfsr_take(input int nbits);
        fwd_types_pkg::data_t value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | fwd_types_pkg::data_t'(lfsr_state[0]);
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic logic depends(
        input fwd_types_pkg::reg_addr_t rs,
        input fwd_types_pkg::reg_addr_t rd
    );
        return rs == rd && rs != 0;
    endfunction

    function automatic fwd_types_pkg::data_t id_value(
        input bypass_sel_pkg::bypass_id_sel_e sel,
        input fwd_types_pkg::data_t           rf
    );
        if (sel == SEL_EX) begin
            return ex_result_i;
        end else if (sel == SEL_MEM) begin
            return mem_result_i;
        end else if (sel == SEL_WB) begin
            return wb_result_i;
        end
        return rf;
    endfunction

    // A producer already taken in decode needs no late correction
    function automatic bypass_sel_pkg::bypass_ex_sel_e late_sel(
        input row_t                           r,
        input fwd_types_pkg::reg_addr_t       rs,
        input bypass_sel_pkg::bypass_id_sel_e id_sel
    );
        if (r.vex && depends(rs, r.rd_ex) && id_sel != SEL_EX) begin
            return bypass_sel_pkg::MEM_BYPASS;
        end
        if (r.vmem && depends(rs, r.rd_mem) && id_sel != SEL_EX && id_sel != SEL_MEM) begin
            return bypass_sel_pkg::WB_BYPASS;
        end
        return bypass_sel_pkg::NO_BYPASS;
    endfunction

    function automatic bypass_sel_pkg::bypass_ex_sel_e store_sel(input row_t r);
        if (r.vex && r.ld_ex && depends(r.rs_b, r.rd_ex)) begin
            return bypass_sel_pkg::MEM_BYPASS;
        end
        if (r.vmem && r.ld_mem && depends(r.rs_b, r.rd_mem)) begin
            return bypass_sel_pkg::WB_BYPASS;
        end
        return bypass_sel_pkg::NO_BYPASS;
    endfunction

    function automatic fwd_types_pkg::data_t corrected(
        input bypass_sel_pkg::bypass_ex_sel_e sel,
        input fwd_types_pkg::data_t           held
    );
        if (sel == bypass_sel_pkg::MEM_BYPASS) begin
            return mem_result_i;
        end else if (sel == bypass_sel_pkg::WB_BYPASS) begin
            return wb_result_i;
        end
        return held;
    endfunction

    task automatic drive_row(input row_t r);
        rst_n_i             = !r.rst;
        valid_id_i          = r.vid;
        rs_a_id_i           = r.rs_a;
        rs_b_id_i           = r.rs_b;
        valid_ex_i          = r.vex;
        rd_ex_i             = r.rd_ex;
        data_produced_ex_i  = r.dp_ex;
        is_load_ex_i        = r.ld_ex;
        valid_mem_i         = r.vmem;
        rd_mem_i            = r.rd_mem;
        data_produced_mem_i = r.dp_mem;
        is_load_mem_i       = r.ld_mem;
        valid_wb_i          = r.vwb;
        rd_wb_i             = r.rd_wb;
        rf_rdata_a_i        = lfsr_take(DATA_W);
        rf_rdata_b_i        = lfsr_take(DATA_W);
        ex_result_i         = lfsr_take(DATA_W);
        mem_result_i        = lfsr_take(DATA_W);
        wb_result_i         = lfsr_take(DATA_W);
    endtask

    task automatic check_data(
        input string                test,
        input string                what,
        input fwd_types_pkg::data_t expected,
        input fwd_types_pkg::data_t actual
    );
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %h actual %h", test, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "%s: wrong %s", test, what);
        end
    endtask

    task automatic check_valid(
        input string test,
        input logic  expected,
        input logic  actual
    );
        if (actual !== expected) begin
            $display("Mismatch %s ex_valid_o: expected %b actual %b", test, expected, actual);
            $display("Regression failed");
            $fatal(1, "%s: wrong ex_valid_o", test);
        end
    endtask

    initial begin
        #((NUM_ROWS + 20) * 4);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        row_t                           r;
        logic                           en;
        logic                           prev_rst;
        string                          prev_name;
        logic                           prev_valid;
        fwd_types_pkg::data_t           prev_a;
        fwd_types_pkg::data_t           prev_b;
        bypass_sel_pkg::bypass_ex_sel_e prev_sel_a;
        bypass_sel_pkg::bypass_ex_sel_e prev_sel_b;
        bypass_sel_pkg::bypass_ex_sel_e prev_sel_load;
        fwd_types_pkg::data_t           exp_a;
        fwd_types_pkg::data_t           exp_b;
        fwd_types_pkg::data_t           exp_ex_b;

        // rst vid vex rd_ex dp ld vmem rd_mem dp ld vwb rd_wb rs_a rs_b sel_a sel_b
        rows = '{
            '{0, 1, 1, 5, 1, 0, 1, 6, 1, 0, 1, 7, 1, 2, SEL_RF, SEL_RF},
            '{0, 1, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 0, 0, SEL_RF, SEL_RF},
            '{0, 1, 1, 1, 1, 0, 1, 1, 1, 0, 1, 1, 1, 2, SEL_EX, SEL_RF},
            '{0, 1, 1, 3, 1, 0, 1, 1, 1, 0, 1, 1, 1, 2, SEL_MEM, SEL_RF},
            '{0, 1, 1, 3, 1, 0, 1, 4, 1, 0, 1, 1, 1, 2, SEL_WB, SEL_RF},
            '{0, 1, 1, 2, 1, 0, 1, 5, 1, 0, 1, 6, 2, 2, SEL_EX, SEL_EX},
            '{0, 1, 1, 2, 0, 0, 1, 5, 1, 0, 1, 6, 2, 3, SEL_RF, SEL_RF},
            '{0, 1, 1, 4, 1, 0, 1, 3, 0, 0, 1, 7, 1, 3, SEL_RF, SEL_RF},
            '{0, 1, 1, 2, 0, 0, 1, 2, 1, 0, 1, 6, 2, 1, SEL_MEM, SEL_RF},
            '{0, 1, 1, 3, 0, 1, 1, 6, 1, 0, 1, 7, 1, 3, SEL_RF, SEL_RF},
            '{0, 1, 1, 5, 1, 0, 1, 4, 0, 1, 1, 7, 1, 4, SEL_RF, SEL_RF},
            '{0, 1, 0, 0, 0, 0, 1, 4, 1, 1, 0, 0, 1, 4, SEL_RF, SEL_MEM},
            '{0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 1, 1, SEL_RF, SEL_RF},
            '{0, 0, 1, 1, 0, 0, 1, 1, 1, 0, 0, 0, 1, 0, SEL_MEM, SEL_RF},
            '{0, 1, 1, 1, 0, 0, 0, 2, 1, 0, 0, 3, 1, 2, SEL_RF, SEL_RF},
            '{1, 1, 1, 1, 1, 0, 1, 1, 1, 0, 1, 1, 1, 1, SEL_RF, SEL_RF},
            '{0, 1, 1, 1, 1, 0, 1, 2, 0, 0, 0, 0, 1, 2, SEL_RF, SEL_RF},
            '{0, 1, 1, 1, 1, 0, 1, 2, 0, 0, 0, 0, 1, 2, SEL_EX, SEL_RF},
            '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, SEL_RF, SEL_RF}
        };
        names = '{
            "no_dep", "src_x0", "prio_ex", "prio_mem", "prio_wb", "both_ex",
            "late_ex_a", "late_mem_b", "late_ex_mem_ready", "load_ex_store",
            "load_mem_store", "load_mem_ready", "invalid_stages", "id_invalid",
            "pre_reset", "reset_mid", "after_reset", "resume", "drain"
        };

        clk_i = 1'b0;
        drive_row('0);
        #1;
        rst_n_i = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;

        // Idle cycle out of reset registers the register file data with valid low
        prev_name     = "reset_release";
        prev_rst      = 1'b0;
        prev_valid    = 1'b0;
        prev_a        = rf_rdata_a_i;
        prev_b        = rf_rdata_b_i;
        prev_sel_a    = bypass_sel_pkg::NO_BYPASS;
        prev_sel_b    = bypass_sel_pkg::NO_BYPASS;
        prev_sel_load = bypass_sel_pkg::NO_BYPASS;

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            @(negedge clk_i);
            drive_row(r);
            // Forwarding needs one clock edge with reset released
            en = !r.rst && !prev_rst;
            if (r.rst) begin
                prev_valid    = 1'b0;
                prev_a        = '0;
                prev_b        = '0;
                prev_sel_a    = bypass_sel_pkg::NO_BYPASS;
                prev_sel_b    = bypass_sel_pkg::NO_BYPASS;
                prev_sel_load = bypass_sel_pkg::NO_BYPASS;
            end
            #1;
            exp_a = id_value(r.sel_a, rf_rdata_a_i);
            exp_b = id_value(r.sel_b, rf_rdata_b_i);
            check_data(names[i], "id_op_a_o", exp_a, id_op_a_o);
            check_data(names[i], "id_op_b_o", exp_b, id_op_b_o);

            // Previous instruction now in EX and corrected with this cycle's results
            exp_ex_b = corrected(prev_sel_b, prev_b);
            check_valid(prev_name, prev_valid, ex_valid_o);
            check_data(prev_name, "ex_op_a_o", corrected(prev_sel_a, prev_a), ex_op_a_o);
            check_data(prev_name, "ex_op_b_o", exp_ex_b, ex_op_b_o);
            check_data(prev_name, "ex_store_data_o", corrected(prev_sel_load, exp_ex_b),
                       ex_store_data_o);

            prev_name     = names[i];
            prev_rst      = r.rst;
            prev_valid    = r.vid && !r.rst;
            prev_a        = r.rst ? '0 : exp_a;
            prev_b        = r.rst ? '0 : exp_b;
            prev_sel_a    = bypass_sel_pkg::NO_BYPASS;
            prev_sel_b    = bypass_sel_pkg::NO_BYPASS;
            prev_sel_load = bypass_sel_pkg::NO_BYPASS;
            if (en && r.vid) begin
                prev_sel_a    = late_sel(r, r.rs_a, r.sel_a);
                prev_sel_b    = late_sel(r, r.rs_b, r.sel_b);
                prev_sel_load = store_sel(r);
            end
        end

        @(negedge clk_i);
        $display("Regression passed");
        $finish;
    end

endmodule : forwarding_tb

//--- list.f
+incdir+logic
logic/fwd_types_pkg.sv
logic/bypass_sel_pkg.sv
logic/dependency_check.sv
logic/bypass_controller.sv
logic/id_operand_mux.sv
logic/ex_operand_stage.sv
logic/forwarding_unit.sv
test/forwarding_properties.sv
test/forwarding_tb.sv
